/* hdl/soc_pkg.sv */
package soc_pkg;

	// wishbone side, single 32-bit word per access
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int SEL_WIDTH = 4;

	// memory line geometry
	localparam int LINE_WIDTH = 128;
	localparam int LINE_BYTES = 16;
	localparam int LINE_WORDS = 4;
	// index field of a line request
	localparam int LINE_IDX_WIDTH = 16;

	// region codes in adr[31:28]
	localparam logic [3:0] REGION_MEM = 4'h0;
	localparam logic [3:0] REGION_LED = 4'h1;

	// led register byte offsets
	localparam logic [3:0] LED_OFS_OUT = 4'h0;
	localparam logic [3:0] LED_OFS_TOGGLE = 4'h4;

	// master to slave, held until ack or err
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_WIDTH-1:0] adr;
		logic [DATA_WIDTH-1:0] dat;
		logic [SEL_WIDTH-1:0] sel;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic ack;
		logic err;
		logic [DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	// one line, seen as words by the adapter and as bytes by the ram
	typedef union packed {
		logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] words;
		logic [LINE_BYTES-1:0][7:0] bytes;
	} line_t;

	typedef struct packed {
		logic en;
		logic we;
		logic [LINE_IDX_WIDTH-1:0] idx;
		line_t data;
		logic [LINE_BYTES-1:0] strb;
	} line_req_t;

endpackage

/* hdl/line_ram.sv */
`timescale 1ns/1ps

module line_ram #(
	parameter int LINE_DEPTH = 256
) (
	input logic init_calib_complete,
	input logic sys_resetn,
	input soc_pkg::line_req_t line_req,
	output soc_pkg::line_t rd_line
);
	import soc_pkg::*;

	localparam int IDX_BITS = $clog2(LINE_DEPTH);

	line_t mem [LINE_DEPTH];
	logic [IDX_BITS-1:0] addr;

	// low index bits address the array
	assign addr = line_req.idx[IDX_BITS-1:0];

	// byte-masked write
	always_ff @(posedge init_calib_complete) begin
		if (line_req.en && line_req.we) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (line_req.strb[b]) begin
					mem[addr].bytes[b] <= line_req.data.bytes[b];
				end
			end
		end
	end

	// registered read, one edge after en
	always_ff @(posedge init_calib_complete) begin
		if (line_req.en && !line_req.we) begin
			rd_line <= mem[addr];
		end
	end

	// decoder keeps out-of-range lines away
	assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		line_req.en |-> (32'(line_req.idx) < LINE_DEPTH));

endmodule

/* hdl/width_adapter.sv */
`timescale 1ns/1ps

module width_adapter (
	input logic init_calib_complete,
	input logic sys_resetn,
	input soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp,
	output soc_pkg::line_req_t line_req,
	input soc_pkg::line_t rd_line
);
	import soc_pkg::*;

	localparam int LANE_BITS = $clog2(LINE_WORDS);

	logic [LANE_BITS-1:0] lane;
	logic [LANE_BITS-1:0] lane_q;
	logic issue;
	logic pending;
	logic ack_q;
	logic [DATA_WIDTH-1:0] rdat_q;
	line_t wr_line;

	// word lane inside the line
	assign lane = req.adr[2 +: LANE_BITS];

	// new request only when idle
	assign issue = req.cyc & req.stb & ~pending & ~ack_q;

	always_comb begin
		// bus word into its lane, other lanes masked by strb
		wr_line = '0;
		wr_line.words[lane] = req.dat;

		line_req.en = issue;
		line_req.we = req.we;
		line_req.idx = req.adr[4 +: LINE_IDX_WIDTH];
		line_req.data = wr_line;
		// sel shifted up to the lane's bytes
		line_req.strb = '0;
		line_req.strb[lane*SEL_WIDTH +: SEL_WIDTH] = req.sel;
	end

	// write acks next edge
	// read waits one more edge for the ram
	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			pending <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= (issue & req.we) | pending;
			pending <= issue & ~req.we;
		end
	end

	// lane kept for the returning line
	always_ff @(posedge init_calib_complete) begin
		if (issue) begin
			lane_q <= lane;
		end
	end

	// rd_line is valid while pending
	always_ff @(posedge init_calib_complete) begin
		if (pending) begin
			rdat_q <= rd_line.words[lane_q];
		end
	end

	// memory path never errors, range is checked upstream
	assign rsp.ack = ack_q;
	assign rsp.err = 1'b0;
	assign rsp.dat = rdat_q;

	// master keeps the same read up while its line is in flight
	assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		pending |-> (req.cyc && req.stb && !req.we && lane == lane_q));

endmodule

/* hdl/led_regs.sv */
`timescale 1ns/1ps

module led_regs #(
	parameter int LED_COUNT = 4
) (
	input logic init_calib_complete,
	input logic sys_resetn,
	input soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp,
	output logic [LED_COUNT-1:0] led
);
	import soc_pkg::*;

	logic [LED_COUNT-1:0] led_q;
	logic [3:0] ofs;
	logic access;
	logic wr_en;
	logic ack_q;
	logic err_q;

	// register select from adr[3:2], as byte offset
	assign ofs = {req.adr[3:2], 2'b00};
	// one access per strobe, none while answering
	assign access = req.cyc & req.stb & ~ack_q & ~err_q;
	// led bits sit in byte lane 0
	assign wr_en = req.we & req.sel[0];

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			led_q <= '0;
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			if (access) begin
				case (ofs)
					LED_OFS_OUT: begin
						ack_q <= 1'b1;
						if (wr_en) begin
							led_q <= req.dat[LED_COUNT-1:0];
						end
					end
					LED_OFS_TOGGLE: begin
						ack_q <= 1'b1;
						// flip where a 1 is written
						if (wr_en) begin
							led_q <= led_q ^ req.dat[LED_COUNT-1:0];
						end
					end
					default: begin
						err_q <= 1'b1;
					end
				endcase
			end
		end
	end

	// both offsets read back the led state
	assign rsp.ack = ack_q;
	assign rsp.err = err_q;
	assign rsp.dat = DATA_WIDTH'(led_q);

	assign led = led_q;

	// answer lands while the master still holds its cycle
	assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		(rsp.ack || rsp.err) |-> (req.cyc && req.stb));

endmodule

/* hdl/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder #(
	parameter int LINE_DEPTH = 256
) (
	input logic init_calib_complete,
	input logic sys_resetn,
	input soc_pkg::wb_req_t host_req,
	output soc_pkg::wb_rsp_t host_rsp,
	output soc_pkg::wb_req_t led_req,
	input soc_pkg::wb_rsp_t led_rsp,
	output soc_pkg::wb_req_t mem_req,
	input soc_pkg::wb_rsp_t mem_rsp
);
	import soc_pkg::*;

	logic [3:0] region;
	logic [ADDR_WIDTH-1:0] line_idx;
	logic hit_led;
	logic hit_mem;
	logic cyc_stb;
	logic err_q;

	// region from the top nibble
	assign region = host_req.adr[ADDR_WIDTH-1:ADDR_WIDTH-4];
	// full line index, bits 4 and up
	assign line_idx = {4'b0, host_req.adr[ADDR_WIDTH-1:4]};

	assign hit_led = (region == REGION_LED);
	// memory only when the line exists
	assign hit_mem = (region == REGION_MEM) && (line_idx < ADDR_WIDTH'(LINE_DEPTH));
	assign cyc_stb = host_req.cyc & host_req.stb;

	// same request to both slaves, stb only where it hits
	always_comb begin
		led_req = host_req;
		led_req.stb = host_req.stb & hit_led;
		mem_req = host_req;
		mem_req.stb = host_req.stb & hit_mem;
	end

	// local err for unmapped or out of range
	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			err_q <= 1'b0;
		end else begin
			// stb is still high in the err cycle, so no second pulse
			err_q <= cyc_stb & ~hit_led & ~hit_mem & ~err_q;
		end
	end

	// only one slave can answer a given cycle
	always_comb begin
		host_rsp.ack = led_rsp.ack | mem_rsp.ack;
		host_rsp.err = led_rsp.err | mem_rsp.err | err_q;
		// read data by region
		if (hit_led) begin
			host_rsp.dat = led_rsp.dat;
		end else begin
			host_rsp.dat = mem_rsp.dat;
		end
	end

	// slaves and local err never collide on the host side
	assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		!(host_rsp.ack && host_rsp.err));

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int LINE_DEPTH = 256,
	parameter int LED_COUNT = 4
) (
	input logic init_calib_complete,
	input logic sys_resetn,
	input soc_pkg::wb_req_t wb_req,
	output soc_pkg::wb_rsp_t wb_rsp,
	output logic [LED_COUNT-1:0] led
);
	import soc_pkg::*;

	// decoder to slaves
	wb_req_t led_req;
	wb_rsp_t led_rsp;
	wb_req_t mem_req;
	wb_rsp_t mem_rsp;

	// adapter to ram
	line_req_t line_req;
	line_t rd_line;

	// address decode, err for unmapped cycles
	bus_decoder #(
		.LINE_DEPTH(LINE_DEPTH)
	) u_bus_decoder (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.host_req(wb_req),
		.host_rsp(wb_rsp),
		.led_req(led_req),
		.led_rsp(led_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	// led registers and pins
	led_regs #(
		.LED_COUNT(LED_COUNT)
	) u_led_regs (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.req(led_req),
		.rsp(led_rsp),
		.led(led)
	);

	// 32 to 128 bit path
	width_adapter u_width_adapter (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.req(mem_req),
		.rsp(mem_rsp),
		.line_req(line_req),
		.rd_line(rd_line)
	);

	// on-chip line memory
	line_ram #(
		.LINE_DEPTH(LINE_DEPTH)
	) u_line_ram (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.line_req(line_req),
		.rd_line(rd_line)
	);

endmodule

/* tb/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;
	import soc_pkg::*;

	localparam int LINE_DEPTH = 256;
	localparam int LED_COUNT = 4;
	// cycles a slave gets before the bus cycle counts as hung
	localparam int RSP_TIMEOUT = 20;
	localparam logic [31:0] LED_MASK = (32'd1 << LED_COUNT) - 32'd1;
	localparam logic [31:0] LED_BASE = {REGION_LED, 28'h0};

	logic init_calib_complete;
	logic sys_resetn;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [LED_COUNT-1:0] led;

	logic [31:0] rng_state;
	// expected words of the lines under test, [line slot][lane]
	logic [31:0] model [3][4];
	int test_lines [3] = '{0, 9, LINE_DEPTH - 1};

	soc_top #(
		.LINE_DEPTH(LINE_DEPTH),
		.LED_COUNT(LED_COUNT)
	) UUT (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.led(led)
	);

	// 8 ns clock
	initial begin
		init_calib_complete = 1'b0;
		forever #4 init_calib_complete = ~init_calib_complete;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// byte address of a word lane in the memory region
	function automatic logic [31:0] mem_addr(input int line, input int lane);
		return 32'((line << 4) | (lane << 2));
	endfunction

	// sel picks new bytes, the rest keep the old word
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = sel[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
		end
		return res;
	endfunction

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic expect_ack(input string name, input logic got_ack, input logic got_err);
		assert (got_ack && !got_err) else begin
			$display("%s: the slave answered with err instead of ack", name);
			abort_run();
		end
	endtask

	task automatic expect_err(input string name, input logic got_ack, input logic got_err);
		assert (got_err && !got_ack) else begin
			$display("%s: the slave answered with ack instead of err", name);
			abort_run();
		end
	endtask

	// one classic cycle, stb low for at least one edge before it
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic got_ack, output logic got_err,
			output logic [31:0] rdat);
		int waited;
		@(posedge init_calib_complete);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.sel = sel;
		got_ack = 1'b0;
		got_err = 1'b0;
		rdat = '0;
		waited = 0;
		// responses are registered, stable at the falling edge
		while (!got_ack && !got_err && waited < RSP_TIMEOUT) begin
			@(negedge init_calib_complete);
			got_ack = wb_rsp.ack;
			got_err = wb_rsp.err;
			rdat = wb_rsp.dat;
			waited++;
		end
		assert (got_ack || got_err) else begin
			$display("bus cycle at address %h got neither ack nor err within %0d cycles",
				adr, RSP_TIMEOUT);
			abort_run();
		end
		// drop the strobe in the cycle after the answer
		@(posedge init_calib_complete);
		#1;
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic got_ack, output logic got_err);
		logic [31:0] unused_dat;
		bus_cycle(1'b1, adr, dat, sel, got_ack, got_err, unused_dat);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic got_ack, output logic got_err,
			output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, 4'hf, got_ack, got_err, rdat);
	endtask

	task automatic test_reset();
		logic ack;
		logic err;
		logic [31:0] rdat;
		check_value("test_reset", 32'h0, 32'(led));
		wb_read(LED_BASE | 32'(LED_OFS_OUT), ack, err, rdat);
		expect_ack("test_reset", ack, err);
		check_value("test_reset", 32'h0, rdat);
	endtask

	task automatic test_led_write();
		logic ack;
		logic err;
		logic [31:0] val;
		logic [31:0] rdat;
		repeat (8) begin
			val = next_random();
			wb_write(LED_BASE | 32'(LED_OFS_OUT), val, 4'hf, ack, err);
			expect_ack("test_led_write", ack, err);
			check_value("test_led_write", val & LED_MASK, 32'(led));
			wb_read(LED_BASE | 32'(LED_OFS_OUT), ack, err, rdat);
			expect_ack("test_led_write", ack, err);
			check_value("test_led_write", val & LED_MASK, rdat);
		end
	endtask

	task automatic test_led_toggle();
		logic ack;
		logic err;
		logic [31:0] flip;
		logic [31:0] expected;
		logic [31:0] rdat;
		// known start pattern
		expected = 32'h5 & LED_MASK;
		wb_write(LED_BASE | 32'(LED_OFS_OUT), expected, 4'hf, ack, err);
		expect_ack("test_led_toggle", ack, err);
		check_value("test_led_toggle", expected, 32'(led));
		repeat (4) begin
			flip = next_random();
			wb_write(LED_BASE | 32'(LED_OFS_TOGGLE), flip, 4'hf, ack, err);
			expect_ack("test_led_toggle", ack, err);
			expected = expected ^ (flip & LED_MASK);
			check_value("test_led_toggle", expected, 32'(led));
			// toggle offset reads the same state
			wb_read(LED_BASE | 32'(LED_OFS_TOGGLE), ack, err, rdat);
			expect_ack("test_led_toggle", ack, err);
			check_value("test_led_toggle", expected, rdat);
		end
	endtask

	// all four lanes of each test line against the model
	task automatic check_lines(input string name);
		logic ack;
		logic err;
		logic [31:0] rdat;
		for (int i = 0; i < 3; i++) begin
			for (int lane = 0; lane < 4; lane++) begin
				wb_read(mem_addr(test_lines[i], lane), ack, err, rdat);
				expect_ack(name, ack, err);
				check_value(name, model[i][lane], rdat);
			end
		end
	endtask

	task automatic test_mem_lanes();
		logic ack;
		logic err;
		logic [31:0] val;
		logic [3:0] part_sel [3];
		int lane;
		part_sel = '{4'b0101, 4'b1000, 4'b0110};
		// fill every lane with full words
		for (int i = 0; i < 3; i++) begin
			for (int l = 0; l < 4; l++) begin
				val = next_random();
				wb_write(mem_addr(test_lines[i], l), val, 4'hf, ack, err);
				expect_ack("test_mem_lanes", ack, err);
				model[i][l] = val;
			end
		end
		check_lines("test_mem_lanes");
		// partial rewrite of one lane per line
		for (int i = 0; i < 3; i++) begin
			lane = (i + 1) % 4;
			val = next_random();
			wb_write(mem_addr(test_lines[i], lane), val, part_sel[i], ack, err);
			expect_ack("test_mem_lanes", ack, err);
			model[i][lane] = merge_bytes(model[i][lane], val, part_sel[i]);
		end
		// neighbour lanes must be untouched
		check_lines("test_mem_lanes");
	endtask

	task automatic test_errors();
		logic ack;
		logic err;
		logic [31:0] rdat;
		logic [31:0] led_before;
		led_before = 32'(led);
		// region 2 is unmapped
		wb_write(32'h2000_0000, next_random(), 4'hf, ack, err);
		expect_err("test_errors", ack, err);
		// line index equal to depth, would alias line 0 if wrapped
		wb_write(32'(LINE_DEPTH << 4), next_random(), 4'hf, ack, err);
		expect_err("test_errors", ack, err);
		wb_read(32'(LINE_DEPTH << 4), ack, err, rdat);
		expect_err("test_errors", ack, err);
		// no led register at offset 8
		wb_write(LED_BASE | 32'h8, next_random(), 4'hf, ack, err);
		expect_err("test_errors", ack, err);
		check_value("test_errors", led_before, 32'(led));
		wb_read(LED_BASE | 32'(LED_OFS_OUT), ack, err, rdat);
		expect_ack("test_errors", ack, err);
		check_value("test_errors", led_before, rdat);
		check_lines("test_errors");
	endtask

	initial begin
		wb_req = '0;
		sys_resetn = 1'b0;
		rng_state = 32'hb25a;
		// two cycles of reset
		repeat (2) @(posedge init_calib_complete);
		#1;
		sys_resetn = 1'b1;
		test_reset();
		test_led_write();
		test_led_toggle();
		test_mem_lanes();
		test_errors();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* soc_bridge.f */
hdl/soc_pkg.sv
hdl/line_ram.sv
hdl/width_adapter.sv
hdl/led_regs.sv
hdl/bus_decoder.sv
hdl/soc_top.sv
tb/tb_soc_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_soc_top
FILELIST  ?= soc_bridge.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
